/* pixel_alu_pkg.sv */
package pixel_alu_pkg;

	localparam int num_pixels    = 8;
	localparam int num_channels  = 3;
	localparam int channel_width = 8;
	localparam int pixel_width   = num_channels * channel_width;
	localparam int product_width = 2 * channel_width;

	typedef logic [channel_width-1:0] channel_t;

	// flag is one-hot; any other value selects no channel
	typedef logic [num_channels-1:0] channel_sel_t;

	localparam channel_sel_t chan_red   = 3'b100;
	localparam channel_sel_t chan_green = 3'b010;
	localparam channel_sel_t chan_blue  = 3'b001;

	typedef enum logic [1:0] {
		op_add  = 2'd0,
		op_sub  = 2'd1,
		op_mul  = 2'd2,
		op_hold = 2'd3	// old divide slot, pixels pass through
	} alu_op_t;

	typedef struct packed {
		channel_t red;	// bits 23:16
		channel_t green;	// bits 15:8
		channel_t blue;	// bits 7:0
	} rgb_t;

	// same 24 bits, seen as a raw word or per channel
	typedef union packed {
		logic [pixel_width-1:0] raw;
		rgb_t                   rgb;
	} pixel_word_u;

	typedef struct packed {
		pixel_word_u pixel;
		logic        carry;
	} lane_result_t;

	// pixel 0 sits in the low 24 bits of the bus
	typedef logic [num_pixels-1:0][pixel_width-1:0] pixel_vec_t;

	function automatic logic is_onehot(channel_sel_t sel);
		logic hit;
		case (sel)
			chan_red, chan_green, chan_blue: begin
				hit = 1'b1;
			end
			default: begin
				hit = 1'b0;
			end
		endcase
		return hit;
	endfunction

	// channel byte named by the flag, 0 when no channel is named
	function automatic channel_t get_channel(
		pixel_word_u  p,
		channel_sel_t sel
	);
		channel_t value;
		case (sel)
			chan_red: begin
				value = p.rgb.red;
			end
			chan_green: begin
				value = p.rgb.green;
			end
			chan_blue: begin
				value = p.rgb.blue;
			end
			default: begin
				value = '0;
			end
		endcase
		return value;
	endfunction

	// writes one channel back, the other two are kept
	function automatic pixel_word_u put_channel(
		pixel_word_u  p,
		channel_sel_t sel,
		channel_t     value
	);
		pixel_word_u merged;
		merged = p;
		case (sel)
			chan_red: begin
				merged.rgb.red = value;
			end
			chan_green: begin
				merged.rgb.green = value;
			end
			chan_blue: begin
				merged.rgb.blue = value;
			end
			default: begin
				merged = p;
			end
		endcase
		return merged;
	endfunction

endpackage

/* pixel_lane.sv */
module pixel_lane (
	input  pixel_alu_pkg::pixel_word_u  pixel,
	input  pixel_alu_pkg::channel_t     scalar,
	input  pixel_alu_pkg::channel_sel_t channel,
	input  pixel_alu_pkg::alu_op_t      op,
	output pixel_alu_pkg::lane_result_t lane_out
);
	import pixel_alu_pkg::*;

	channel_t                 chan_in;	// selected channel byte
	logic                     chan_valid;
	logic                     active;

	logic [channel_width:0]   sum;
	logic [channel_width:0]   diff;
	logic [product_width-1:0] product;

	channel_t                 add_val;
	channel_t                 sub_val;
	channel_t                 mul_val;
	logic                     add_c;
	logic                     sub_c;
	logic                     mul_c;

	channel_t                 chan_out;
	logic                     op_carry;
	pixel_word_u              merged;

	assign chan_valid = is_onehot(channel);
	assign chan_in    = get_channel(pixel, channel);

	// one extra bit holds the carry out or the borrow
	assign sum     = {1'b0, chan_in} + {1'b0, scalar};
	assign diff    = {1'b0, chan_in} - {1'b0, scalar};
	assign product = product_width'(chan_in) * product_width'(scalar);

	assign add_val = sum[channel_width-1:0];
	assign add_c   = sum[channel_width];

	assign sub_val = diff[channel_width-1:0];
	assign sub_c   = diff[channel_width];	// channel < scalar

	assign mul_val = product[channel_width-1:0];
	assign mul_c   = |product[product_width-1:channel_width];	// high byte non-zero

	always_comb begin
		case (op)
			op_add: begin
				chan_out = add_val;
				op_carry = add_c;
			end
			op_sub: begin
				chan_out = sub_val;
				op_carry = sub_c;
			end
			op_mul: begin
				chan_out = mul_val;
				op_carry = mul_c;
			end
			default: begin	// hold
				chan_out = chan_in;
				op_carry = 1'b0;
			end
		endcase
	end

	// no write-back and no carry for hold or a bad flag
	assign active = chan_valid && (op != op_hold);

	always_comb begin
		if (active) begin
			merged = put_channel(pixel, channel, chan_out);
		end else begin
			merged = pixel;
		end
	end

	assign lane_out.pixel = merged;
	assign lane_out.carry = active & op_carry;

endmodule

/* vector_alu.sv */
module vector_alu (
	input  logic                                    clk,
	input  logic                                    reset,
	input  pixel_alu_pkg::pixel_vec_t               pixels,
	input  pixel_alu_pkg::channel_t                 scalar,
	input  pixel_alu_pkg::channel_sel_t             channel,
	input  pixel_alu_pkg::alu_op_t                  op,
	output pixel_alu_pkg::pixel_vec_t               result,
	output logic [pixel_alu_pkg::num_pixels-1:0]    carry_out
);
	import pixel_alu_pkg::*;

	lane_result_t [num_pixels-1:0] lane_res;
	pixel_vec_t                    next_result;
	logic [num_pixels-1:0]         next_carry;

	genvar i;

	// every lane shares scalar, channel and op
	generate
		for (i = 0; i < num_pixels; i++) begin : g_lane
			pixel_lane u_lane (
				.pixel    (pixels[i]),
				.scalar   (scalar),
				.channel  (channel),
				.op       (op),
				.lane_out (lane_res[i])
			);
		end
	endgenerate

	// split lane results back into pixel bus and carry word
	always_comb begin
		for (int n = 0; n < num_pixels; n++) begin
			next_result[n] = lane_res[n].pixel.raw;
			next_carry[n]  = lane_res[n].carry;
		end
	end

	// single output stage, one cycle of latency
	always_ff @(posedge clk) begin
		if (reset) begin
			result    <= '0;
			carry_out <= '0;
		end else begin
			result    <= next_result;
			carry_out <= next_carry;
		end
	end

endmodule

/* vector_alu_checker.sv */
module vector_alu_checker (
	input logic                                 clk,
	input logic                                 reset,
	input pixel_alu_pkg::pixel_vec_t            pixels,
	input pixel_alu_pkg::channel_sel_t          channel,
	input pixel_alu_pkg::alu_op_t               op,
	input pixel_alu_pkg::pixel_vec_t            result,
	input logic [pixel_alu_pkg::num_pixels-1:0] carry_out
);
	import pixel_alu_pkg::*;

	logic [pixel_width-1:0] lane_keep;	// bits that must pass through
	pixel_vec_t             keep;
	logic                   no_write;

	assign no_write = (op == op_hold) || !$onehot(channel);

	always_comb begin
		if (no_write) begin
			lane_keep = '1;
		end else begin
			lane_keep = {{channel_width{~channel[2]}},
				{channel_width{~channel[1]}},
				{channel_width{~channel[0]}}};
		end
	end

	assign keep = {num_pixels{lane_keep}};

	reset_clears: assert property (@(posedge clk)
		reset |=> (result == '0 && carry_out == '0))
		else $error("outputs not cleared in the cycle after a reset edge");

	// hold op or a bad flag never carries
	hold_no_carry: assert property (@(posedge clk) disable iff (reset)
		no_write |=> carry_out == '0)
		else $error("carry set after a hold op or a channel flag that is not one-hot");

	pass_through: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> (result & $past(keep)) == ($past(pixels) & $past(keep)))
		else $error("an unselected channel did not pass through");

endmodule

bind vector_alu vector_alu_checker chk0 (
	.clk       (clk),
	.reset     (reset),
	.pixels    (pixels),
	.channel   (channel),
	.op        (op),
	.result    (result),
	.carry_out (carry_out)
);

/* vector_alu_tb.sv */
module vector_alu_tb;
	import pixel_alu_pkg::*;

	localparam int    reset_cycles  = 8;
	localparam int    random_cycles = 200;
	localparam int    max_cases     = 1000;
	localparam string case_file     = "vector_alu_cases.txt";

	logic                  clk;
	logic                  reset;
	pixel_vec_t            pixels;
	channel_t              scalar;
	channel_sel_t          channel;
	alu_op_t               op;
	pixel_vec_t            result;
	logic [num_pixels-1:0] carry_out;

	// expectation for the vector driven one clock earlier
	logic                  pend_valid;
	string                 pend_name;
	int                    pend_index;
	pixel_vec_t            pend_result;
	logic [num_pixels-1:0] pend_carry;

	int     errors;
	int     checks;
	integer seed;

	// scratch for the stimulus process
	int                     fd;
	int                     code;
	int                     fields;
	int                     n;
	logic                   done;
	logic [8*128-1:0]       line_buf;
	logic [8*32-1:0]        name_buf;
	logic [7:0]             op_val;
	logic [2:0]             chan_val;
	logic [7:0]             scal_val;
	logic [pixel_width-1:0] in_pix [num_pixels];
	logic [pixel_width-1:0] exp_pix [num_pixels];
	logic [7:0]             exp_carry;
	logic [31:0]            rnd;
	pixel_vec_t             vec;
	pixel_vec_t             exp_vec;
	logic [num_pixels-1:0]  exp_c;
	channel_t               s;
	channel_sel_t           ch;
	alu_op_t                o;

	vector_alu dut0 (
		.clk       (clk),
		.reset     (reset),
		.pixels    (pixels),
		.scalar    (scalar),
		.channel   (channel),
		.op        (op),
		.result    (result),
		.carry_out (carry_out)
	);

	always #50 clk = ~clk;

	// expected {pixel, carry} of one lane under add, sub or mul
	function automatic logic [pixel_width:0] ref_lane(
		logic [pixel_width-1:0] pix,
		channel_t               sc,
		channel_sel_t           sel,
		alu_op_t                opc
	);
		logic [pixel_width-1:0] outp;
		channel_t               v;
		logic [15:0]            wide;
		logic                   carry;
		logic                   picked;
		outp = pix;
		carry = 1'b0;
		wide = '0;
		picked = 1'b1;
		case (sel)
			3'b100: begin
				v = pix[23:16];
			end
			3'b010: begin
				v = pix[15:8];
			end
			3'b001: begin
				v = pix[7:0];
			end
			default: begin
				v = '0;
				picked = 1'b0;
			end
		endcase
		if (picked && opc != op_hold) begin
			case (opc)
				op_add: begin
					wide = 16'(v) + 16'(sc);
					carry = wide > 16'd255;
				end
				op_sub: begin
					wide = 16'(v) - 16'(sc);
					carry = v < sc;	// borrow
				end
				op_mul: begin
					wide = 16'(v) * 16'(sc);
					carry = wide > 16'd255;
				end
				default: begin
					wide = 16'(v);
				end
			endcase
			case (sel)
				3'b100: begin
					outp[23:16] = wide[7:0];
				end
				3'b010: begin
					outp[15:8] = wide[7:0];
				end
				default: begin
					outp[7:0] = wide[7:0];
				end
			endcase
		end
		return {outp, carry};
	endfunction

	task automatic expected_vector(
		input  pixel_vec_t            pix,
		input  channel_t              sc,
		input  channel_sel_t          sel,
		input  alu_op_t               opc,
		output pixel_vec_t            res,
		output logic [num_pixels-1:0] cy
	);
		logic [pixel_width:0] lane;
		for (int k = 0; k < num_pixels; k++) begin
			lane = ref_lane(pix[k], sc, sel, opc);
			res[k] = lane[pixel_width:1];
			cy[k] = lane[0];
		end
	endtask

	task automatic check_outputs();
		if (pend_valid) begin
			checks++;
			assert (result == pend_result) else begin
				errors++;
				$display("ERROR %s #%0d result: expected %h, actual %h",
					pend_name, pend_index, pend_result, result);
			end
			checks++;
			assert (carry_out == pend_carry) else begin
				errors++;
				$display("ERROR %s #%0d carry: expected %h, actual %h",
					pend_name, pend_index, pend_carry, carry_out);
			end
		end
	endtask

	// checks the last vector and drives the next one on the falling edge
	task automatic drive_vector(
		input string                 name,
		input int                    index,
		input pixel_vec_t            pix,
		input channel_t              sc,
		input channel_sel_t          sel,
		input alu_op_t               opc,
		input pixel_vec_t            exp_res,
		input logic [num_pixels-1:0] exp_cy
	);
		@(negedge clk);
		check_outputs();
		pixels = pix;
		scalar = sc;
		channel = sel;
		op = opc;
		pend_name = name;
		pend_index = index;
		pend_result = exp_res;
		pend_carry = exp_cy;
		pend_valid = 1'b1;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		errors = 0;
		checks = 0;
		seed = 32'ha17;
		pend_valid = 1'b0;
		for (int k = 0; k < num_pixels; k++) begin
			rnd = $random(seed);
			pixels[k] = rnd[23:0];	// junk that reset must hide
		end
		scalar = 8'h5a;
		channel = chan_red;
		op = op_add;

		pend_name = "reset";
		pend_result = '0;
		pend_carry = '0;
		for (int k = 0; k < reset_cycles; k++) begin
			@(negedge clk);
			pend_index = k;
			pend_valid = 1'b1;
			check_outputs();
		end
		reset = 1'b0;
		expected_vector(pixels, scalar, channel, op, pend_result, pend_carry);
		pend_name = "after_reset";
		pend_index = 0;

		fd = $fopen(case_file, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the case file %s.", case_file);
		end else begin
			code = $fgets(line_buf, fd);	// two header lines
			code = $fgets(line_buf, fd);
			done = 1'b0;
			n = 0;
			while (!done && n < max_cases) begin
				code = $fscanf(fd, " %s %h %b %h", name_buf, op_val, chan_val, scal_val);
				if (code <= 0) begin
					done = 1'b1;
				end else begin
					fields = code;
					for (int k = 0; k < num_pixels; k++) begin
						fields += $fscanf(fd, " %h", in_pix[k]);
					end
					for (int k = 0; k < num_pixels; k++) begin
						fields += $fscanf(fd, " %h", exp_pix[k]);
					end
					fields += $fscanf(fd, " %h", exp_carry);
					if (fields != 21) begin
						errors++;
						$display("Case %0d in the case file is incomplete.", n);
						done = 1'b1;
					end else begin
						for (int k = 0; k < num_pixels; k++) begin
							vec[k] = in_pix[k];
							exp_vec[k] = exp_pix[k];
						end
						drive_vector($sformatf("%0s", name_buf), n, vec, scal_val,
							chan_val, alu_op_t'(op_val[1:0]), exp_vec, exp_carry);
						n++;
					end
				end
			end
			if (!done) begin
				errors++;
				$display("The case file did not end within %0d cases.", max_cases);
			end
			if (n == 0) begin
				errors++;
				$display("No cases were read from the case file.");
			end
			$fclose(fd);
		end

		for (int r = 0; r < random_cycles; r++) begin
			for (int k = 0; k < num_pixels; k++) begin
				rnd = $random(seed);
				vec[k] = rnd[23:0];
			end
			rnd = $random(seed);
			s = rnd[31:24];
			if (rnd[20:18] == 3'd0) begin
				s = {7'd0, rnd[21]};	// scalar 0 or 1 now and then
			end
			case (rnd[10:8])
				3'd0, 3'd1: begin
					ch = chan_red;
				end
				3'd2, 3'd3: begin
					ch = chan_green;
				end
				3'd4, 3'd5: begin
					ch = chan_blue;
				end
				default: begin
					ch = rnd[14:12];
				end
			endcase
			o = alu_op_t'(rnd[17:16]);
			expected_vector(vec, s, ch, o, exp_vec, exp_c);
			drive_vector("random", r, vec, s, ch, o, exp_vec, exp_c);
		end
		@(negedge clk);
		check_outputs();
		pend_valid = 1'b0;

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* vector_alu_cases.txt */
# line 1: name, op (0 add 1 sub 2 mul 3 hold), channel flag (r g b bits), scalar, pixels 0 to 7
# line 2: expected pixels 0 to 7, expected carry word (bit n is pixel n), all values in hex
add_red_01 0 100 01 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
010000 00FFFF 112030 81807F 02FE02 808081 C1A050 101E2D 02
add_green_80 0 010 80 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
008000 FF7FFF 10A030 80007F 017E02 7F0081 C02050 0F9E2D 7A
add_blue_ff 0 001 FF 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
0000FF FFFFFE 10202F 80807E 01FE01 7F8080 C0A04F 0F1E2C FE
add_red_00 0 100 00 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D 00
sub_red_01 1 100 01 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
FF0000 FEFFFF 0F2030 7F807F 00FE02 7E8081 BFA050 0E1E2D 01
sub_green_80 1 010 80 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
008000 FF7FFF 10A030 80007F 017E02 7F0081 C02050 0F9E2D 85
sub_blue_ff 1 001 FF 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000001 FFFF00 102031 808080 01FE03 7F8082 C0A051 0F1E2E FD
sub_blue_00 1 001 00 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D 00
mul_red_02 2 100 02 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FEFFFF 202030 00807F 02FE02 FE8081 80A050 1E1E2D 4A
mul_green_00 2 010 00 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FF00FF 100030 80007F 010002 7F0081 C00050 0F002D 00
mul_blue_01 2 001 01 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D 00
mul_red_10 2 100 10 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 F0FFFF 002030 00807F 10FE02 F08081 00A050 F01E2D 6E
mul_green_ff 2 010 FF 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FF01FF 10E030 80807F 010202 7F8081 C06050 0FE22D FE
mul_blue_03 2 001 03 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFD 102090 80807D 01FE06 7F8083 C0A0F0 0F1E87 2A
hold_red 3 100 55 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D 00
none_000_add 0 000 55 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D 00
none_011_sub 1 011 55 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D 00
none_111_mul 2 111 55 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D 00
hold_blue_ff 3 001 FF 000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D
000000 FFFFFF 102030 80807F 01FE02 7F8081 C0A050 0F1E2D 00
add_red_7f 0 100 7F 123456 89ABCD FEDCBA 0A0B0C 55AA55 AA55AA 808080 7F7F7F
913456 08ABCD 7DDCBA 890B0C D4AA55 2955AA FF8080 FE7F7F 26
sub_green_55 1 010 55 123456 89ABCD FEDCBA 0A0B0C 55AA55 AA55AA 808080 7F7F7F
12DF56 8956CD FE87BA 0AB60C 555555 AA00AA 802B80 7F2A7F 09
mul_blue_05 2 001 05 123456 89ABCD FEDCBA 0A0B0C 55AA55 AA55AA 808080 7F7F7F
1234AE 89AB01 FEDCA2 0A0B3C 55AAA9 AA5552 808080 7F7F7B F7
mul_red_02_q 2 100 02 123456 89ABCD FEDCBA 0A0B0C 55AA55 AA55AA 808080 7F7F7F
243456 12ABCD FCDCBA 140B0C AAAA55 5455AA 008080 FE7F7F 66
add_green_01 0 010 01 123456 89ABCD FEDCBA 0A0B0C 55AA55 AA55AA 808080 7F7F7F
123556 89ACCD FEDDBA 0A0C0C 55AB55 AA56AA 808180 7F807F 00
sub_blue_80 1 001 80 123456 89ABCD FEDCBA 0A0B0C 55AA55 AA55AA 808080 7F7F7F
1234D6 89AB4D FEDC3A 0A0B8C 55AAD5 AA552A 808000 7F7FFF 99
none_110_add 0 110 01 123456 89ABCD FEDCBA 0A0B0C 55AA55 AA55AA 808080 7F7F7F
123456 89ABCD FEDCBA 0A0B0C 55AA55 AA55AA 808080 7F7F7F 00

/* project.f */
pixel_alu_pkg.sv
pixel_lane.sv
vector_alu.sv
vector_alu_checker.sv
vector_alu_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
	verilator --binary --assert --top-module vector_alu_tb \
		-f project.f -o vector_alu_sim &&
	./obj_dir/vector_alu_sim | tee /dev/stderr | grep -q "Result: PASSED" &&
	echo "simulation ok" ||
	{ echo "simulation not ok"; exit 1; }
